//--- common/sat_pkg.sv
package sat_pkg;

    // default problem sizes, overridden from the top level
    localparam int NSAT_DEF     = 3;
    localparam int NUM_VARS_DEF = 16;
    localparam int MAX_OCC_DEF  = 4;

    // noise threshold out of 65536, roughly p = 0.2
    localparam int NOISE_DEF = 13107;

    // xorshift32 seed, must be nonzero
    localparam logic [31:0] PRNG_SEED = 32'h2545_f491;

    // shift amounts: left, right, left
    localparam int PRNG_SHIFT_A = 13;
    localparam int PRNG_SHIFT_B = 17;
    localparam int PRNG_SHIFT_C = 5;

    // flip step sequencing
    typedef enum logic [2:0] {
        IDLE,
        READ,
        EVAL,
        SELECT,
        FLIP,
        DONE
    } ctrl_state_e;

endpackage

//--- hdl/flip_ctrl.sv
`timescale 1ns/1ps

module flip_ctrl #(
    parameter int NSAT = sat_pkg::NSAT_DEF
) (
    input  logic                                   clk_i,
    input  logic                                   rst_i,
    input  logic                                   start_i,
    output logic                                   load_clause_o,
    output logic [((NSAT > 1) ? $clog2(NSAT) : 1)-1:0] lit_idx_o,
    output logic                                   count_en_o,
    output logic                                   select_en_o,
    output logic                                   flip_en_o,
    output logic                                   busy_o,
    output logic                                   done_o
);

    import sat_pkg::*;

    localparam int IDX_W = (NSAT > 1) ? $clog2(NSAT) : 1;

    ctrl_state_e      state_q;
    logic [IDX_W-1:0] lit_idx_q;
    logic             last_lit;

    assign last_lit = (lit_idx_q == IDX_W'(NSAT - 1));

    // start only counts when idle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= IDLE;
            lit_idx_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q   <= READ;
                        lit_idx_q <= '0;
                    end
                end
                // table address goes out here
                READ: state_q <= EVAL;
                // row is valid, count gets captured
                EVAL: begin
                    if (last_lit) begin
                        state_q <= SELECT;
                    end else begin
                        lit_idx_q <= lit_idx_q + 1'b1;
                        state_q   <= READ;
                    end
                end
                SELECT:  state_q <= FLIP;
                FLIP:    state_q <= DONE;
                DONE:    state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // strobes decoded straight from state
    assign load_clause_o = (state_q == IDLE) && start_i;
    assign lit_idx_o     = lit_idx_q;
    assign count_en_o    = (state_q == EVAL);
    assign select_en_o   = (state_q == SELECT);
    assign flip_en_o     = (state_q == FLIP);
    assign done_o        = (state_q == DONE);
    assign busy_o        = (state_q != IDLE);

endmodule

//--- hdl/xorshift_prng.sv
`timescale 1ns/1ps

module xorshift_prng (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        step_i,
    output logic [31:0] rand_o
);

    import sat_pkg::*;

    logic [31:0] state_q;
    logic [31:0] stage_a;
    logic [31:0] stage_b;
    logic [31:0] stage_c;

    // three shift-xor stages
    assign stage_a = state_q ^ (state_q << PRNG_SHIFT_A);
    assign stage_b = stage_a ^ (stage_a >> PRNG_SHIFT_B);
    assign stage_c = stage_b ^ (stage_b << PRNG_SHIFT_C);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= PRNG_SEED;
        end else if (step_i) begin
            state_q <= stage_c;
        end
    end

    // value after the step, so the consumer sees it in the stepping cycle
    assign rand_o = stage_c;

endmodule

//--- tables/occurrence_table.sv
`timescale 1ns/1ps

module occurrence_table #(
    parameter int NUM_VARS = sat_pkg::NUM_VARS_DEF,
    parameter int NSAT     = sat_pkg::NSAT_DEF,
    parameter int MAX_OCC  = sat_pkg::MAX_OCC_DEF
) (
    input  logic                                             clk_i,
    input  logic                                             wr_en_i,
    input  logic [$clog2(NUM_VARS):0]                        wr_addr_i,
    input  logic [MAX_OCC*(NSAT-1)*($clog2(NUM_VARS)+1)-1:0] wr_lits_i,
    input  logic [MAX_OCC-1:0]                               wr_mask_i,
    input  logic [$clog2(NUM_VARS):0]                        rd_addr_i,
    output logic [MAX_OCC*(NSAT-1)*($clog2(NUM_VARS)+1)-1:0] lits_o,
    output logic [MAX_OCC-1:0]                               mask_o
);

    localparam int LIT_W = $clog2(NUM_VARS) + 1;
    localparam int ROW_W = MAX_OCC * (NSAT - 1) * LIT_W;
    localparam int DEPTH = 2 * NUM_VARS;

    // one row per literal, both polarities of each variable
    logic [ROW_W-1:0]   lits_mem [DEPTH];
    logic [MAX_OCC-1:0] mask_mem [DEPTH];

    // load port
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            lits_mem[wr_addr_i] <= wr_lits_i;
            mask_mem[wr_addr_i] <= wr_mask_i;
        end
    end

    // registered read, row lands one cycle after the address
    always_ff @(posedge clk_i) begin
        lits_o <= lits_mem[rd_addr_i];
        mask_o <= mask_mem[rd_addr_i];
    end

endmodule

//--- tables/variable_table.sv
`timescale 1ns/1ps

module variable_table #(
    parameter int NUM_VARS = sat_pkg::NUM_VARS_DEF
) (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        wr_en_i,
    input  logic [$clog2(NUM_VARS)-1:0] wr_addr_i,
    input  logic                        wr_data_i,
    input  logic                        flip_en_i,
    input  logic [$clog2(NUM_VARS)-1:0] flip_addr_i,
    output logic [NUM_VARS-1:0]         values_o
);

    // current assignment, one bit per variable
    logic [NUM_VARS-1:0] values_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            values_q <= '0;
        end else if (wr_en_i) begin
            // load while idle
            values_q[wr_addr_i] <= wr_data_i;
        end else if (flip_en_i) begin
            // commit the chosen flip
            values_q[flip_addr_i] <= ~values_q[flip_addr_i];
        end
    end

    // whole vector out, evaluator muxes many reads in parallel
    assign values_o = values_q;

endmodule

//--- eval/break_counter.sv
`timescale 1ns/1ps

module break_counter #(
    parameter int NUM_VARS = sat_pkg::NUM_VARS_DEF,
    parameter int NSAT     = sat_pkg::NSAT_DEF,
    parameter int MAX_OCC  = sat_pkg::MAX_OCC_DEF
) (
    input  logic                                             clk_i,
    input  logic                                             rst_i,
    input  logic                                             count_en_i,
    input  logic [MAX_OCC*(NSAT-1)*($clog2(NUM_VARS)+1)-1:0] lits_i,
    input  logic [MAX_OCC-1:0]                               mask_i,
    input  logic [NUM_VARS-1:0]                              values_i,
    output logic [$clog2(MAX_OCC+1)-1:0]                     count_o
);

    localparam int VAR_W = $clog2(NUM_VARS);
    localparam int LIT_W = VAR_W + 1;
    localparam int CNT_W = $clog2(MAX_OCC + 1);

    logic [MAX_OCC-1:0] broken;
    logic [CNT_W-1:0]   num_broken;

    // clause breaks when valid and none of its other literals hold
    always_comb begin
        logic [LIT_W-1:0] lit;
        logic             any_true;
        broken = '0;
        for (int k = 0; k < MAX_OCC; k++) begin
            any_true = 1'b0;
            for (int j = 0; j < NSAT - 1; j++) begin
                lit = lits_i[(k * (NSAT - 1) + j) * LIT_W +: LIT_W];
                // true when value differs from the negation bit
                any_true = any_true | (values_i[lit[VAR_W-1:0]] ^ lit[LIT_W-1]);
            end
            broken[k] = mask_i[k] & ~any_true;
        end
    end

    // popcount
    always_comb begin
        num_broken = '0;
        for (int k = 0; k < MAX_OCC; k++) begin
            num_broken = num_broken + CNT_W'(broken[k]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_o <= '0;
        end else if (count_en_i) begin
            count_o <= num_broken;
        end
    end

endmodule

//--- eval/flip_selector.sv
`timescale 1ns/1ps

module flip_selector #(
    parameter int NUM_VARS        = sat_pkg::NUM_VARS_DEF,
    parameter int NSAT            = sat_pkg::NSAT_DEF,
    parameter int MAX_OCC         = sat_pkg::MAX_OCC_DEF,
    parameter int NOISE_THRESHOLD = sat_pkg::NOISE_DEF
) (
    input  logic                                       clk_i,
    input  logic                                       rst_i,
    input  logic                                       load_clause_i,
    input  logic [NSAT*($clog2(NUM_VARS)+1)-1:0]       clause_i,
    input  logic [((NSAT > 1) ? $clog2(NSAT) : 1)-1:0] lit_idx_i,
    input  logic                                       count_en_i,
    input  logic [$clog2(MAX_OCC+1)-1:0]               count_i,
    input  logic                                       select_en_i,
    input  logic [31:0]                                rand_i,
    output logic [$clog2(NUM_VARS):0]                  rd_lit_o,
    output logic [$clog2(NUM_VARS)-1:0]                flip_var_o,
    output logic [$clog2(MAX_OCC+1)-1:0]               break_count_o,
    output logic                                       random_pick_o
);

    localparam int VAR_W = $clog2(NUM_VARS);
    localparam int LIT_W = VAR_W + 1;
    localparam int IDX_W = (NSAT > 1) ? $clog2(NSAT) : 1;
    localparam int CNT_W = $clog2(MAX_OCC + 1);

    logic [NSAT*LIT_W-1:0] clause_q;
    logic [LIT_W-1:0]      cur_lit;
    logic                  cnt_vld_q;
    logic [IDX_W-1:0]      cnt_idx_q;
    logic [CNT_W-1:0]      counts_q   [NSAT];
    logic [CNT_W-1:0]      cur_counts [NSAT];
    logic [CNT_W-1:0]      min_q;
    logic [IDX_W-1:0]      min_idx_q;
    logic [CNT_W-1:0]      best_cnt;
    logic [IDX_W-1:0]      best_idx;
    logic                  noisy;
    logic [IDX_W-1:0]      rand_idx;
    logic [IDX_W-1:0]      pick_idx;

    // read address is the negated literal
    assign cur_lit  = clause_q[lit_idx_i * LIT_W +: LIT_W];
    assign rd_lit_o = {~cur_lit[LIT_W-1], cur_lit[VAR_W-1:0]};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            clause_q  <= '0;
            cnt_vld_q <= 1'b0;
            cnt_idx_q <= '0;
            min_q     <= '1;
            min_idx_q <= '0;
        end else begin
            // count register lags count_en by one cycle
            cnt_vld_q <= count_en_i;
            cnt_idx_q <= lit_idx_i;
            if (load_clause_i) begin
                clause_q  <= clause_i;
                min_q     <= '1;
                min_idx_q <= '0;
            end else if (cnt_vld_q) begin
                min_q     <= best_cnt;
                min_idx_q <= best_idx;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (cnt_vld_q) begin
            counts_q[cnt_idx_q] <= count_i;
        end
    end

    // last count arrives in the select cycle, so merge it in here
    always_comb begin
        cur_counts = counts_q;
        if (cnt_vld_q) begin
            cur_counts[cnt_idx_q] = count_i;
        end
    end

    // strict compare keeps ties on the lower index
    assign best_cnt = (cnt_vld_q && count_i < min_q) ? count_i : min_q;
    assign best_idx = (cnt_vld_q && count_i < min_q) ? cnt_idx_q : min_idx_q;

    // noise test on low half, random index from high half
    assign noisy    = (rand_i[15:0] < 16'(NOISE_THRESHOLD));
    assign rand_idx = IDX_W'(rand_i[31:16] % NSAT);
    assign pick_idx = noisy ? rand_idx : best_idx;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            flip_var_o    <= '0;
            break_count_o <= '0;
            random_pick_o <= 1'b0;
        end else if (select_en_i) begin
            flip_var_o    <= clause_q[pick_idx * LIT_W +: VAR_W];
            break_count_o <= cur_counts[pick_idx];
            random_pick_o <= noisy;
        end
    end

endmodule

//--- hdl/sat_flip_top.sv
`timescale 1ns/1ps

module sat_flip_top #(
    parameter int NSAT            = sat_pkg::NSAT_DEF,
    parameter int NUM_VARS        = sat_pkg::NUM_VARS_DEF,
    parameter int MAX_OCC         = sat_pkg::MAX_OCC_DEF,
    parameter int NOISE_THRESHOLD = sat_pkg::NOISE_DEF
) (
    input  logic                                          clk_i,
    input  logic                                          rst_i,
    input  logic                                          var_wr_en_i,
    input  logic [$clog2(NUM_VARS)-1:0]                   var_wr_addr_i,
    input  logic                                          var_wr_data_i,
    input  logic                                          occ_wr_en_i,
    input  logic [$clog2(NUM_VARS):0]                     occ_wr_addr_i,
    input  logic [MAX_OCC*(NSAT-1)*($clog2(NUM_VARS)+1)-1:0] occ_wr_lits_i,
    input  logic [MAX_OCC-1:0]                            occ_wr_mask_i,
    input  logic [NSAT*($clog2(NUM_VARS)+1)-1:0]          clause_i,
    input  logic                                          start_i,
    output logic                                          busy_o,
    output logic                                          done_o,
    output logic [$clog2(NUM_VARS)-1:0]                   flip_var_o,
    output logic [$clog2(MAX_OCC+1)-1:0]                  break_count_o,
    output logic                                          random_pick_o
);

    localparam int VAR_W = $clog2(NUM_VARS);
    localparam int LIT_W = VAR_W + 1;
    localparam int IDX_W = (NSAT > 1) ? $clog2(NSAT) : 1;
    localparam int CNT_W = $clog2(MAX_OCC + 1);
    localparam int ROW_W = MAX_OCC * (NSAT - 1) * LIT_W;

    // controller strobes
    logic             load_clause;
    logic [IDX_W-1:0] lit_idx;
    logic             count_en;
    logic             select_en;
    logic             flip_en;

    // datapath
    logic [31:0]         rand_val;
    logic [LIT_W-1:0]    rd_lit;
    logic [ROW_W-1:0]    occ_lits;
    logic [MAX_OCC-1:0]  occ_mask;
    logic [NUM_VARS-1:0] var_values;
    logic [CNT_W-1:0]    brk_count;
    logic [VAR_W-1:0]    sel_var;

    flip_ctrl #(.NSAT(NSAT)) u_flip_ctrl (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .start_i       (start_i),
        .load_clause_o (load_clause),
        .lit_idx_o     (lit_idx),
        .count_en_o    (count_en),
        .select_en_o   (select_en),
        .flip_en_o     (flip_en),
        .busy_o        (busy_o),
        .done_o        (done_o)
    );

    xorshift_prng u_prng (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .step_i (select_en),
        .rand_o (rand_val)
    );

    occurrence_table #(.NUM_VARS(NUM_VARS), .NSAT(NSAT), .MAX_OCC(MAX_OCC)) u_occ_table (
        .clk_i     (clk_i),
        .wr_en_i   (occ_wr_en_i),
        .wr_addr_i (occ_wr_addr_i),
        .wr_lits_i (occ_wr_lits_i),
        .wr_mask_i (occ_wr_mask_i),
        .rd_addr_i (rd_lit),
        .lits_o    (occ_lits),
        .mask_o    (occ_mask)
    );

    variable_table #(.NUM_VARS(NUM_VARS)) u_var_table (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .wr_en_i     (var_wr_en_i),
        .wr_addr_i   (var_wr_addr_i),
        .wr_data_i   (var_wr_data_i),
        .flip_en_i   (flip_en),
        .flip_addr_i (sel_var),
        .values_o    (var_values)
    );

    break_counter #(.NUM_VARS(NUM_VARS), .NSAT(NSAT), .MAX_OCC(MAX_OCC)) u_break_counter (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .count_en_i (count_en),
        .lits_i     (occ_lits),
        .mask_i     (occ_mask),
        .values_i   (var_values),
        .count_o    (brk_count)
    );

    flip_selector #(
        .NUM_VARS        (NUM_VARS),
        .NSAT            (NSAT),
        .MAX_OCC         (MAX_OCC),
        .NOISE_THRESHOLD (NOISE_THRESHOLD)
    ) u_flip_selector (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .load_clause_i (load_clause),
        .clause_i      (clause_i),
        .lit_idx_i     (lit_idx),
        .count_en_i    (count_en),
        .count_i       (brk_count),
        .select_en_i   (select_en),
        .rand_i        (rand_val),
        .rd_lit_o      (rd_lit),
        .flip_var_o    (sel_var),
        .break_count_o (break_count_o),
        .random_pick_o (random_pick_o)
    );

    assign flip_var_o = sel_var;

endmodule

//--- dv/tb_sat_flip.sv
`timescale 1ns/1ps

module tb_sat_flip;

    import sat_pkg::*;

    localparam int NSAT        = NSAT_DEF;
    localparam int NUM_VARS    = NUM_VARS_DEF;
    localparam int MAX_OCC     = MAX_OCC_DEF;
    localparam int NOISE       = NOISE_DEF;
    localparam int VAR_W       = $clog2(NUM_VARS);
    localparam int LIT_W       = VAR_W + 1;
    localparam int CNT_W       = $clog2(MAX_OCC + 1);
    localparam int ROW_W       = MAX_OCC * (NSAT - 1) * LIT_W;
    localparam int LATENCY     = 2 * NSAT + 3;
    // 200 flips, the busy-start flip and one flip after it
    localparam int NUM_FLIPS   = 202;
    localparam int LOAD_CYCLES = 16 + 3 * NUM_VARS + 4;
    localparam int CYCLE_LIMIT = NUM_FLIPS * (LATENCY + 4) + LOAD_CYCLES + 100;

    logic                  clk_i;
    logic                  rst_i;
    logic                  var_wr_en;
    logic [VAR_W-1:0]      var_wr_addr;
    logic                  var_wr_data;
    logic                  occ_wr_en;
    logic [LIT_W-1:0]      occ_wr_addr;
    logic [ROW_W-1:0]      occ_wr_lits;
    logic [MAX_OCC-1:0]    occ_wr_mask;
    logic [NSAT*LIT_W-1:0] clause;
    logic                  start;
    logic                  busy;
    logic                  done;
    logic [VAR_W-1:0]      flip_var;
    logic [CNT_W-1:0]      break_count;
    logic                  random_pick;

    // reference model state
    logic [LIT_W-1:0]    occ_lits [2*NUM_VARS][MAX_OCC][NSAT-1];
    logic [MAX_OCC-1:0]  occ_mask [2*NUM_VARS];
    logic [NUM_VARS-1:0] model_vals;
    logic [31:0]         model_prng;
    logic [15:0]         lfsr;
    int                  errors;
    int                  checks;
    int                  random_picks;
    int                  cycle_cnt = 0;

    sat_flip_top #(
        .NSAT            (NSAT),
        .NUM_VARS        (NUM_VARS),
        .MAX_OCC         (MAX_OCC),
        .NOISE_THRESHOLD (NOISE)
    ) u_sat_flip_top (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .var_wr_en_i   (var_wr_en),
        .var_wr_addr_i (var_wr_addr),
        .var_wr_data_i (var_wr_data),
        .occ_wr_en_i   (occ_wr_en),
        .occ_wr_addr_i (occ_wr_addr),
        .occ_wr_lits_i (occ_wr_lits),
        .occ_wr_mask_i (occ_wr_mask),
        .clause_i      (clause),
        .start_i       (start),
        .busy_o        (busy),
        .done_o        (done),
        .flip_var_o    (flip_var),
        .break_count_o (break_count),
        .random_pick_o (random_pick)
    );

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // watchdog
    initial begin
        wait (cycle_cnt >= CYCLE_LIMIT);
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("ERRORS FOUND");
        $finish;
    end

    // galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // xorshift32 with shifts 13 left then 17 right then 5 left
    function automatic logic [31:0] xorshift_next(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // literal holds when value differs from negation bit
    function automatic bit lit_is_true(input logic [LIT_W-1:0] lit);
        return model_vals[lit[VAR_W-1:0]] != lit[LIT_W-1];
    endfunction

    // clauses of the negated literal left with no true literal
    function automatic int breaks_for(input logic [LIT_W-1:0] lit);
        logic [LIT_W-1:0] row;
        int               n;
        bit               sat;
        row = {~lit[LIT_W-1], lit[VAR_W-1:0]};
        n = 0;
        for (int k = 0; k < MAX_OCC; k++) begin
            sat = 1'b0;
            for (int j = 0; j < NSAT - 1; j++) begin
                if (lit_is_true(occ_lits[row][k][j])) sat = 1'b1;
            end
            if (occ_mask[row][k] && !sat) n++;
        end
        return n;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic load_vars();
        logic b;
        for (int v = 0; v < NUM_VARS; v++) begin
            b = 1'(rand_bits(1));
            model_vals[v] = b;
            @(posedge clk_i);
            var_wr_en   <= 1'b1;
            var_wr_addr <= VAR_W'(v);
            var_wr_data <= b;
        end
        @(posedge clk_i);
        var_wr_en <= 1'b0;
    endtask

    task automatic load_occ();
        logic [ROW_W-1:0]   row;
        logic [MAX_OCC-1:0] mask;
        for (int r = 0; r < 2 * NUM_VARS; r++) begin
            row = '0;
            for (int k = 0; k < MAX_OCC; k++) begin
                for (int j = 0; j < NSAT - 1; j++) begin
                    occ_lits[r][k][j] = LIT_W'(rand_bits(LIT_W));
                    row[(k * (NSAT - 1) + j) * LIT_W +: LIT_W] = occ_lits[r][k][j];
                end
            end
            mask = MAX_OCC'(rand_bits(MAX_OCC));
            occ_mask[r] = mask;
            @(posedge clk_i);
            occ_wr_en   <= 1'b1;
            occ_wr_addr <= LIT_W'(r);
            occ_wr_lits <= row;
            occ_wr_mask <= mask;
        end
        @(posedge clk_i);
        occ_wr_en <= 1'b0;
    endtask

    // one flip on a random clause with an optional start pulse while busy
    task automatic run_flip(input string name, input bit poke);
        logic [LIT_W-1:0]      lits [NSAT];
        int                    counts [NSAT];
        logic [NSAT*LIT_W-1:0] clause_val;
        logic                  noisy;
        int                    best;
        int                    pick;
        int                    latency;
        for (int i = 0; i < NSAT; i++) begin
            lits[i] = LIT_W'(rand_bits(LIT_W));
            clause_val[i * LIT_W +: LIT_W] = lits[i];
            counts[i] = breaks_for(lits[i]);
        end
        model_prng = xorshift_next(model_prng);
        noisy = (model_prng[15:0] < NOISE);
        // greedy pick with ties to lowest index
        best = 0;
        for (int i = 1; i < NSAT; i++) begin
            if (counts[i] < counts[best]) best = i;
        end
        pick = best;
        if (noisy) pick = int'(model_prng[31:16]) % NSAT;
        @(posedge clk_i);
        clause <= clause_val;
        start  <= 1'b1;
        // dut samples start here
        @(posedge clk_i);
        start <= 1'b0;
        @(negedge clk_i);
        latency = 1;
        check_value({name, " busy"}, 1, busy);
        while (!done) begin
            @(posedge clk_i);
            start <= poke && (latency == 3);
            // a different clause offered with the busy start must not be taken
            if (poke && (latency == 3)) begin
                clause <= ~clause_val;
            end
            @(negedge clk_i);
            latency++;
            check_value({name, " busy"}, 1, busy);
        end
        check_value({name, " latency"}, LATENCY, latency);
        check_value({name, " random_pick"}, noisy, random_pick);
        check_value({name, " flip_var"}, lits[pick][VAR_W-1:0], flip_var);
        check_value({name, " break_count"}, counts[pick], break_count);
        if (noisy) random_picks++;
        model_vals[lits[pick][VAR_W-1:0]] = ~model_vals[lits[pick][VAR_W-1:0]];
    endtask

    initial begin
        clk_i        = 1'b0;
        rst_i        = 1'b1;
        var_wr_en    = 1'b0;
        var_wr_addr  = '0;
        var_wr_data  = 1'b0;
        occ_wr_en    = 1'b0;
        occ_wr_addr  = '0;
        occ_wr_lits  = '0;
        occ_wr_mask  = '0;
        clause       = '0;
        start        = 1'b0;
        lfsr         = 16'd37;
        model_prng   = PRNG_SEED;
        model_vals   = '0;
        errors       = 0;
        checks       = 0;
        random_picks = 0;
        repeat (16) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_value("reset busy", 0, busy);
        check_value("reset done", 0, done);
        check_value("reset flip_var", 0, flip_var);
        check_value("reset break_count", 0, break_count);
        check_value("reset random_pick", 0, random_pick);
        load_vars();
        load_occ();
        for (int n = 0; n < 200; n++) begin
            run_flip($sformatf("flip %0d", n), 1'b0);
        end
        run_flip("busy start", 1'b1);
        // ignored start must not launch a second flip
        repeat (LATENCY + 3) begin
            @(negedge clk_i);
            check_value("busy start extra done", 0, done);
            check_value("busy start idle", 0, busy);
        end
        // prng stepped once or this pick diverges
        run_flip("after busy start", 1'b0);
        $display("checks %0d, errors %0d, random picks %0d", checks, errors, random_picks);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- flist.f
common/sat_pkg.sv
hdl/flip_ctrl.sv
hdl/xorshift_prng.sv
tables/occurrence_table.sv
tables/variable_table.sv
eval/break_counter.sv
eval/flip_selector.sv
hdl/sat_flip_top.sv
dv/tb_sat_flip.sv

//--- Bender.yml
package:
  name: sat_flip

sources:
  - common/sat_pkg.sv
  - hdl/flip_ctrl.sv
  - hdl/xorshift_prng.sv
  - tables/occurrence_table.sv
  - tables/variable_table.sv
  - eval/break_counter.sv
  - eval/flip_selector.sv
  - hdl/sat_flip_top.sv
  - target: test
    files:
      - dv/tb_sat_flip.sv
